// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module alu import rv_pkg::*; (
    input  alu_op_e             op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result
);

    logic [`RV_SHAMT_W-1:0] shamt;
    logic                   lt_s;
    logic                   lt_u;

    assign shamt = b[`RV_SHAMT_W-1:0]; // upper bits of b ignored
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt; // sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module decode_stage import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  logic [`RV_XLEN-1:0] instruction,
    input  logic [`RV_XLEN-1:0] pc_in,
    output logic                illegal_d,
    dec_if.decode               dec
);

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    alu_op_e             op_n;
    src_a_e              src_a_n;
    logic                use_imm_n;
    logic [`RV_XLEN-1:0] imm_n;
    logic                bad;

    assign opcode = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign imm_i = {{(`RV_XLEN-`RV_IMM_I_W){instruction[31]}},
                    instruction[`RV_XLEN-1 -: `RV_IMM_I_W]};
    assign imm_u = {instruction[`RV_XLEN-1 -: `RV_IMM_U_W], {(`RV_XLEN-`RV_IMM_U_W){1'b0}}};

    always_comb begin
        op_n      = ALU_ADD;
        src_a_n   = SRC_A_RS1;
        use_imm_n = 1'b1;
        imm_n     = imm_i;
        bad       = 1'b0;
        case (opcode)
            OPC_LUI: begin
                src_a_n = SRC_A_ZERO; // 0 + imm_u
                imm_n   = imm_u;
            end
            OPC_AUIPC: begin
                src_a_n = SRC_A_PC;
                imm_n   = imm_u;
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: op_n = ALU_ADD; // no subi
                    F3_SLL: begin
                        op_n = ALU_SLL;
                        bad  = (funct7 != F7_BASE);
                    end
                    F3_SLT:  op_n = ALU_SLT;
                    F3_SLTU: op_n = ALU_SLTU;
                    F3_XOR:  op_n = ALU_XOR;
                    F3_SRL_SRA: begin
                        op_n = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        bad  = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                    end
                    F3_OR:   op_n = ALU_OR;
                    F3_AND:  op_n = ALU_AND;
                endcase
            end
            OPC_OP: begin
                use_imm_n = 1'b0;
                case (funct3)
                    F3_ADD_SUB: op_n = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     op_n = ALU_SLL;
                    F3_SLT:     op_n = ALU_SLT;
                    F3_SLTU:    op_n = ALU_SLTU;
                    F3_XOR:     op_n = ALU_XOR;
                    F3_SRL_SRA: op_n = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      op_n = ALU_OR;
                    F3_AND:     op_n = ALU_AND;
                endcase
                // alt funct7 only exists for sub and sra
                if ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)) begin
                    bad = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                end else begin
                    bad = (funct7 != F7_BASE);
                end
            end
            default: bad = 1'b1; // loads, stores, jumps, system, unknown
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec.valid <= 1'b0;
            illegal_d <= 1'b0;
        end else begin
            dec.valid <= instr_valid & ~bad;
            illegal_d <= instr_valid & bad;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec.op      <= op_n;
            dec.src_a   <= src_a_n;
            dec.use_imm <= use_imm_n;
            dec.rd      <= instruction[11:7];
            dec.rs1     <= instruction[19:15];
            dec.rs2     <= instruction[24:20];
            dec.imm     <= imm_n;
            dec.pc      <= pc_in;
        end
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module execute_stage import rv_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      illegal_d,
    dec_if.execute                    dec,
    rf_if.client                      rf,
    output logic                      wb_valid,
    output logic                      illegal,
    output logic [`RV_REG_ADDR_W-1:0] wb_addr,
    output logic [`RV_XLEN-1:0]       wb_data
);

    logic                fwd1;
    logic                fwd2;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_out;

    assign rf.raddr1 = dec.rs1;
    assign rf.raddr2 = dec.rs2;

    // previous result is not in the register file yet
    assign fwd1 = wb_valid && (wb_addr != '0) && (wb_addr == dec.rs1);
    assign fwd2 = wb_valid && (wb_addr != '0) && (wb_addr == dec.rs2);

    assign rs1_val = fwd1 ? wb_data : rf.rdata1;
    assign rs2_val = fwd2 ? wb_data : rf.rdata2;

    always_comb begin
        case (dec.src_a)
            SRC_A_PC:   op_a = dec.pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_val;
        endcase
    end

    assign op_b = dec.use_imm ? dec.imm : rs2_val;

    alu i_alu (
        .op     (dec.op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_out)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
            wb_addr  <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= dec.valid;
            illegal  <= illegal_d; // never reaches the write port
            if (dec.valid) begin
                wb_addr <= dec.rd;
                wb_data <= alu_out;
            end
        end
    end

    // result register feeds the register file one edge later
    assign rf.we    = wb_valid;
    assign rf.waddr = wb_addr;
    assign rf.wdata = wb_data;

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module reg_file (
    input  logic clk,
    input  logic rst_n,
    rf_if.regs   rf
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we && (rf.waddr != '0)) begin // x0 is never written
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // x0 reads as zero regardless of array content
    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/10ps -f vlog.f \
    --top-module tb_rv_int_core -o tb_rv_int_core \
    && ./obj_dir/tb_rv_int_core | tee /dev/stderr | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and instruction word
`define RV_XLEN 32

// register file geometry
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// shift amount taken from the low bits of operand b
`define RV_SHAMT_W 5

// immediate field widths
`define RV_IMM_I_W 12 // addi, slti, ... and shift immediates
`define RV_IMM_U_W 20 // lui and auipc, placed in bits 31:12

`endif

// File: rv_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

interface dec_if import rv_pkg::*;;
    logic                      valid;
    alu_op_e                   op;
    src_a_e                    src_a;
    logic                      use_imm; // operand b is imm instead of rs2
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]       imm;     // already extended or shifted
    logic [`RV_XLEN-1:0]       pc;

    modport decode (output valid, op, src_a, use_imm, rd, rs1, rs2, imm, pc);
    modport execute (input valid, op, src_a, use_imm, rd, rs1, rs2, imm, pc);
endinterface

interface rf_if;
    logic [`RV_REG_ADDR_W-1:0] raddr1;
    logic [`RV_REG_ADDR_W-1:0] raddr2;
    logic [`RV_XLEN-1:0]       rdata1;
    logic [`RV_XLEN-1:0]       rdata2;
    logic                      we;
    logic [`RV_REG_ADDR_W-1:0] waddr;
    logic [`RV_XLEN-1:0]       wdata;

    modport client (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
    modport regs (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);
endinterface

`default_nettype wire

// File: rv_int_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module rv_int_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  logic [`RV_XLEN-1:0]       instruction,
    input  logic [`RV_XLEN-1:0]       pc_in,
    output logic                      wb_valid,
    output logic [`RV_REG_ADDR_W-1:0] wb_addr,
    output logic [`RV_XLEN-1:0]       wb_data,
    output logic                      illegal
);

    logic illegal_d; // decode flag, one cycle ahead of illegal

    dec_if dec_bus ();
    rf_if  rf_bus ();

    decode_stage i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .pc_in       (pc_in),
        .illegal_d   (illegal_d),
        .dec         (dec_bus.decode)
    );

    execute_stage i_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .illegal_d (illegal_d),
        .dec       (dec_bus.execute),
        .rf        (rf_bus.client),
        .wb_valid  (wb_valid),
        .illegal   (illegal),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf_bus.regs)
    );

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // major opcodes still handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011, // register-immediate group
        OPC_OP     = 7'b0110011  // register-register group
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // where the first alu operand comes from
    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1, // auipc
        SRC_A_ZERO = 2'd2  // lui
    } src_a_e;

endpackage

`default_nettype wire

// File: tb_rv_int_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_config.svh"

module tb_rv_int_core;

    localparam int MAX_CYCLES = 2000; // about 3x the issued instructions
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] F7_ALT = 7'b0100000; // sub, sra, srai

    typedef struct packed {
        logic                      valid;
        logic                      ill;
        logic [`RV_REG_ADDR_W-1:0] addr;
        logic [`RV_XLEN-1:0]       data;
    } exp_t;

    logic clk, rst_n, instr_valid, wb_valid, illegal;
    logic [`RV_XLEN-1:0] instruction, pc_in, wb_data;
    logic [`RV_REG_ADDR_W-1:0] wb_addr;
    logic [`RV_XLEN-1:0] ref_regs [`RV_NUM_REGS]; // architectural register model
    logic [`RV_REG_ADDR_W-1:0] last_rd [2] = '{default: '0};
    logic [31:0] lfsr = 32'd78333;
    exp_t exp_q [$];
    exp_t exp_in = '0;  // outcome of the instruction being driven
    exp_t exp_now = '0; // outcome due at the outputs
    int errors = 0;
    int cycles, issued, test_errs;

    rv_int_core i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // one entry per cycle, so the head trails issue by the pipeline depth
    always @(posedge clk) begin
        exp_q.push_back(exp_in);
        if (exp_q.size() > 1) begin
            exp_now <= exp_q.pop_front();
        end
    end

    // outputs change on the rising edge and are compared on the falling one
    a_flags: assert property (@(negedge clk) disable iff (!rst_n)
        (wb_valid == exp_now.valid) && (illegal == exp_now.ill))
    else begin
        $display("mismatch at %0t: wb_valid %b illegal %b, expected %b %b", $time,
                 wb_valid, illegal, exp_now.valid, exp_now.ill);
        errors++;
    end

    a_result: assert property (@(negedge clk) disable iff (!rst_n)
        exp_now.valid |-> (wb_addr == exp_now.addr) && (wb_data == exp_now.data))
    else begin
        $display("mismatch at %0t: x%0d = %h, expected x%0d = %h", $time,
                 wb_addr, wb_data, exp_now.addr, exp_now.data);
        errors++;
    end

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1); // galois step
        end
        return r;
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] shr_arith;
        shr_arith = $signed(a) >>> b[4:0];
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            3'b101: return alt ? $unsigned(shr_arith) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] pick_alu_instr(input logic dep);
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [11:0] imm;
        logic alt, reg_form;
        reg_form = 1'(next_bits(1));
        alt = 1'(next_bits(1));
        f3 = 3'(next_bits(3));
        rd = 5'(next_bits(5));
        rs1 = 5'(next_bits(5));
        rs2 = 5'(next_bits(5));
        imm = 12'(next_bits(12));
        if (dep) begin // sources from the last two destinations
            rs1 = last_rd[1'(next_bits(1))];
            rs2 = last_rd[1'(next_bits(1))];
            rd = (rd == 5'd0) ? 5'd1 : rd;
        end
        last_rd[1] = last_rd[0];
        last_rd[0] = rd;
        alt = alt && ((f3 == 3'b000 && reg_form) || f3 == 3'b101);
        if (f3[1:0] == 2'b01) begin
            imm[11:5] = alt ? F7_ALT : 7'd0; // shift immediates carry funct7
        end
        if (reg_form) begin
            return {alt ? F7_ALT : 7'd0, rs2, rs1, f3, rd, OP_REG};
        end
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    task automatic issue(input logic [31:0] ins, input logic [31:0] pc);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] a, b;
        logic legal, alt;
        exp_t e;
        f3 = ins[14:12];
        f7 = ins[31:25];
        a = ref_regs[ins[19:15]];
        b = {{20{ins[31]}}, ins[31:20]};
        alt = (f7 == F7_ALT);
        legal = 1'b1;
        e = '0;
        case (ins[6:0])
            OP_LUI: e.data = {ins[31:12], 12'd0};
            OP_AUIPC: e.data = pc + {ins[31:12], 12'd0};
            OP_IMM: begin
                legal = (f3 == 3'b001) ? (f7 == 7'd0) : ((f3 != 3'b101) || (f7 == 7'd0) || alt);
                e.data = alu_model(f3, alt && (f3 == 3'b101), a, b);
            end
            OP_REG: begin
                b = ref_regs[ins[24:20]];
                legal = (f7 == 7'd0) || (alt && (f3 == 3'b000 || f3 == 3'b101));
                e.data = alu_model(f3, alt, a, b);
            end
            default: legal = 1'b0; // loads, stores, jumps, fence, system
        endcase
        e.valid = legal;
        e.ill = !legal;
        e.addr = ins[11:7];
        if (legal && (ins[11:7] != 5'd0)) begin
            ref_regs[ins[11:7]] = e.data;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instruction = ins;
        pc_in = pc;
        exp_in = e;
        issued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            exp_in = '0;
        end
    endtask

    task automatic close_test(input string name);
        idle(4); // last result is compared half a cycle after it appears
        $display("test %-14s %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instruction = '0;
        pc_in = '0;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idle(4); // nothing may come out before the first issue
        issue({12'h7a5, 5'd0, 3'b000, 5'd5, OP_IMM}, '0);
        close_test("reset_state");

        repeat (300) issue(pick_alu_instr(1'b0), '0);
        close_test("random_alu");

        repeat (250) issue(pick_alu_instr(1'b1), '0);
        close_test("forwarding");

        repeat (12) begin
            issue({20'(next_bits(20)), 5'(next_bits(5)), OP_LUI}, '0);
            issue({20'(next_bits(20)), 5'(next_bits(5)), OP_AUIPC}, next_bits(30) << 2);
        end
        close_test("upper_imm");

        issue({12'd123, 5'd7, 3'b000, 5'd0, OP_IMM}, '0);         // x0 target still pulses
        issue({7'd0, 5'd0, 5'd0, 3'b110, 5'd3, OP_REG}, '0);      // no forwarding of x0
        idle(2);
        issue({12'd5, 5'd0, 3'b000, 5'd4, OP_IMM}, '0);           // x0 from register file
        close_test("x0_writes");

        issue({12'h010, 5'd2, 3'b010, 5'd9, 7'b0000011}, '0);     // lw
        issue({7'd0, 5'd9, 5'd2, 3'b010, 5'd4, 7'b0100011}, '0);  // sw
        issue({7'd0, 5'd9, 5'd2, 3'b000, 5'd8, 7'b1100011}, '0);  // beq
        issue({20'h00100, 5'd9, 7'b1101111}, '0);                 // jal
        issue(32'h0ff0000f, '0);                                  // fence
        issue(32'h00000073, '0);                                  // ecall
        issue({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd9, OP_REG}, '0);
        issue({7'b0000001, 5'd3, 5'd1, 3'b101, 5'd9, OP_IMM}, '0);
        issue({7'd0, 5'd0, 5'd9, 3'b000, 5'd10, OP_REG}, '0);     // x9 must be unchanged
        close_test("illegal");

        $display("tests 6, instructions %0d, errors %0d", issued, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
rv_pkg.sv
rv_if.sv
decode_stage.sv
reg_file.sv
alu.sv
execute_stage.sv
rv_int_core.sv
tb_rv_int_core.sv
